// File: common/ctrl_pkg.sv
////////////////////
// Types and constants shared by the pipeline controller blocks
// Pulled in by a wildcard import in each module header
////////////////////
package ctrl_pkg;

  // Main controller FSM states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FUNCTIONAL,
    SLEEP,
    DEBUG_TAKEN
  } ctrl_state_e;

  // Debug status, one-hot so each bit backs one status output
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } dbg_status_e;

  // Source of the next fetch PC
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_DRET
  } pc_mux_e;

  // Handler kind when pc_mux selects PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION,
    EXC_PC_IRQ,
    EXC_PC_DBD
  } exc_pc_mux_e;

  // Debug cause as written to dcsr.cause
  typedef enum logic [2:0] {
    EBREAK  = 3'd1,
    HALTREQ = 3'd3
  } dbg_cause_e;

  // One bit per stage, bit 0 is IF and bit 3 is WB
  typedef logic [3:0] stage_mask_t;
  typedef logic [4:0] irq_id_t;
  // mcause, top bit flags an interrupt
  typedef logic [5:0] csr_cause_t;

  localparam stage_mask_t STAGE_IF = 4'b0001;
  localparam stage_mask_t STAGE_ID = 4'b0010;
  localparam stage_mask_t STAGE_EX = 4'b0100;
  localparam stage_mask_t STAGE_WB = 4'b1000;

  // Synchronous exception causes
  localparam irq_id_t EXC_CAUSE_INSTR_BUS_FAULT = 5'd1;
  localparam irq_id_t EXC_CAUSE_ILLEGAL         = 5'd2;
  localparam irq_id_t EXC_CAUSE_BREAKPOINT      = 5'd3;
  localparam irq_id_t EXC_CAUSE_ECALL_M         = 5'd11;

endpackage

// File: common/ctrl_event_if.sv
////////////////////
// Event and permission levels passed between the controller blocks
// All fields are valid in the cycle they are driven, no handshake
////////////////////
interface ctrl_event_if import ctrl_pkg::*; (input logic clk);

  // Decoded stage events
  logic    exception_wb;
  irq_id_t exc_cause_wb;
  logic    wfi_wb;
  logic    dret_wb;
  logic    ebreak_wb;
  logic    lsu_wb;
  logic    branch_taken_ex;
  logic    jump_taken_id;

  // Debug and interrupt permissions
  logic       pending_debug;
  logic       debug_allowed;
  logic       pending_irq;
  logic       irq_allowed;
  logic       debug_mode;
  dbg_cause_e debug_cause;

  // Main FSM strobes
  logic debug_enter;
  logic debug_exit;
  logic boot_go;

  modport decoder (
    output exception_wb, exc_cause_wb, wfi_wb, dret_wb, ebreak_wb, lsu_wb,
           branch_taken_ex, jump_taken_id
  );

  modport tracker (
    input  clk, ebreak_wb, lsu_wb, debug_enter, debug_exit, boot_go,
    output pending_debug, debug_allowed, pending_irq, irq_allowed, debug_mode, debug_cause
  );

  modport fsm (
    input  clk, exception_wb, exc_cause_wb, wfi_wb, dret_wb, branch_taken_ex, jump_taken_id,
           pending_debug, debug_allowed, pending_irq, irq_allowed, debug_mode,
    output debug_enter, debug_exit, boot_go
  );

endinterface

// File: hw/ctrl_event_decode.sv
////////////////////
// Qualifies raw per-stage flags with the stage valid bits
// Produces the ID, EX and WB events and the WB exception cause
////////////////////
module ctrl_event_decode import ctrl_pkg::*; (
  // WB stage
  input  logic wb_valid_i,
  input  logic wb_fetch_err_i,
  input  logic wb_illegal_i,
  input  logic wb_ecall_i,
  input  logic wb_ebreak_i,
  input  logic wb_wfi_i,
  input  logic wb_dret_i,
  input  logic wb_lsu_i,

  // EX stage
  input  logic ex_valid_i,
  input  logic ex_branch_i,
  input  logic ex_branch_taken_i,

  // ID stage
  input  logic id_valid_i,
  input  logic id_jump_i,
  input  logic jr_stall_i,

  ctrl_event_if.decoder ev
);

  //////////////////////
  // WB events
  //////////////////////

  // Any synchronous exception source on a live instruction
  assign ev.exception_wb = wb_valid_i &&
                           (wb_fetch_err_i || wb_illegal_i || wb_ecall_i || wb_ebreak_i);

  // Cause priority follows the order a fault is detected
  always_comb begin
    if (wb_fetch_err_i) begin
      ev.exc_cause_wb = EXC_CAUSE_INSTR_BUS_FAULT;
    end else if (wb_illegal_i) begin
      ev.exc_cause_wb = EXC_CAUSE_ILLEGAL;
    end else if (wb_ecall_i) begin
      ev.exc_cause_wb = EXC_CAUSE_ECALL_M;
    end else begin
      ev.exc_cause_wb = EXC_CAUSE_BREAKPOINT;
    end
  end

  assign ev.wfi_wb    = wb_valid_i && wb_wfi_i;
  assign ev.dret_wb   = wb_valid_i && wb_dret_i;
  assign ev.ebreak_wb = wb_valid_i && wb_ebreak_i;
  // LSU op in WB still waits for its response
  assign ev.lsu_wb    = wb_valid_i && wb_lsu_i;

  //////////////////////
  // EX and ID events
  //////////////////////

  // Branch resolved taken in EX
  assign ev.branch_taken_ex = ex_valid_i && ex_branch_i && ex_branch_taken_i;

  // Jump target is only usable once the register operand is ready
  assign ev.jump_taken_id = id_valid_i && id_jump_i && !jr_stall_i;

endmodule

// File: hw/ctrl_debug_tracker.sv
////////////////////
// Debug mode, sticky debug request and outstanding data request tracking
// Derives the pending and allowed flags and runs the debug status FSM
////////////////////
module ctrl_debug_tracker import ctrl_pkg::*; (
  input  logic clk,
  input  logic rst_n,

  input  logic debug_req_i,
  input  logic debug_ebreakm_i,
  input  logic irq_req_i,
  input  logic data_req_i,
  input  logic ex_done_i,

  ctrl_event_if.tracker ev,

  output logic debug_havereset_o,
  output logic debug_running_o,
  output logic debug_halted_o
);

  logic        debug_mode_q;
  logic        debug_req_q;
  // Data request issued while its instruction is still in EX
  logic        data_req_q;
  logic        ebreak_to_debug;
  dbg_status_e status_cs;
  dbg_status_e status_ns;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_mode_q <= 1'b0;
      debug_req_q  <= 1'b0;
      data_req_q   <= 1'b0;
      status_cs    <= HAVERESET;
    end else begin
      // Entry wins, exit only comes from inside debug mode anyway
      if (ev.debug_enter) begin
        debug_mode_q <= 1'b1;
      end else if (ev.debug_exit) begin
        debug_mode_q <= 1'b0;
      end
      // Hold a short request pulse until debug mode is reached
      if (debug_req_i) begin
        debug_req_q <= 1'b1;
      end else if (debug_mode_q) begin
        debug_req_q <= 1'b0;
      end
      if (data_req_i && !ex_done_i) begin
        data_req_q <= 1'b1;
      end else if (ex_done_i) begin
        data_req_q <= 1'b0;
      end
      status_cs <= status_ns;
    end
  end

  assign ebreak_to_debug = ev.ebreak_wb && debug_ebreakm_i;

  assign ev.debug_mode    = debug_mode_q;
  assign ev.pending_debug = !debug_mode_q && (debug_req_i || debug_req_q || ebreak_to_debug);
  // No kill while an LSU transfer is in flight
  assign ev.debug_allowed = !ev.lsu_wb && !data_req_q;
  assign ev.pending_irq   = irq_req_i && !debug_mode_q;
  assign ev.irq_allowed   = !ev.lsu_wb && !data_req_q && !debug_mode_q;
  assign ev.debug_cause   = (ebreak_to_debug && !debug_mode_q) ? EBREAK : HALTREQ;

  //////////////////////
  // Debug status FSM
  //////////////////////
  always_comb begin
    status_ns = status_cs;
    case (status_cs)
      HAVERESET: begin
        if (ev.debug_enter) begin
          status_ns = HALTED;
        end else if (ev.boot_go) begin
          status_ns = RUNNING;
        end
      end
      RUNNING: begin
        if (ev.debug_enter) status_ns = HALTED;
      end
      HALTED: begin
        if (ev.debug_exit) status_ns = RUNNING;
      end
      default: status_ns = HAVERESET;
    endcase
  end

  assign debug_havereset_o = (status_cs == HAVERESET);
  assign debug_running_o   = (status_cs == RUNNING);
  assign debug_halted_o    = (status_cs == HALTED);

endmodule

// File: ctrl_fsm/ctrl_main_fsm.sv
////////////////////
// Main pipeline controller FSM
// Drives PC selection, stage halts and kills, and CSR save and restore
////////////////////
module ctrl_main_fsm import ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        fetch_enable_i,
  input  irq_id_t     irq_id_i,
  input  logic        irq_wakeup_i,
  input  logic        mtvec_vectored_i,
  input  logic        wb_valid_i,
  input  logic        ex_valid_i,
  input  logic        id_valid_i,

  ctrl_event_if.fsm   ev,

  output logic        instr_req_o,
  output logic        ctrl_busy_o,
  output logic        pc_set_o,
  output pc_mux_e     pc_mux_o,
  output exc_pc_mux_e exc_pc_mux_o,
  output irq_id_t     exc_vec_idx_o,
  output stage_mask_t halt_o,
  output stage_mask_t kill_o,
  output stage_mask_t csr_save_o,
  output logic        csr_save_cause_o,
  output csr_cause_t  csr_cause_o,
  output logic        csr_restore_dret_o,
  output logic        irq_ack_o,
  output irq_id_t     irq_id_o,
  output logic        debug_csr_save_o
);

  ctrl_state_e state_cs;
  ctrl_state_e state_ns;
  // Oldest stage holding a valid instruction, IF as fallback
  stage_mask_t oldest_stage;
  // Id of the interrupt taken this cycle
  irq_id_t     exc_cause;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_cs <= RESET;
    end else begin
      state_cs <= state_ns;
    end
  end

  always_comb begin
    if (wb_valid_i) begin
      oldest_stage = STAGE_WB;
    end else if (ex_valid_i) begin
      oldest_stage = STAGE_EX;
    end else if (id_valid_i) begin
      oldest_stage = STAGE_ID;
    end else begin
      oldest_stage = STAGE_IF;
    end
  end

  // Vectored mode jumps to base plus 4 times the id
  assign exc_vec_idx_o = mtvec_vectored_i ? exc_cause : '0;

  always_comb begin
    state_ns           = state_cs;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_EXCEPTION;
    exc_cause          = '0;
    halt_o             = '0;
    kill_o             = '0;
    csr_save_o         = '0;
    csr_save_cause_o   = 1'b0;
    csr_cause_o        = '0;
    csr_restore_dret_o = 1'b0;
    irq_ack_o          = 1'b0;
    irq_id_o           = '0;
    debug_csr_save_o   = 1'b0;
    ev.debug_enter     = 1'b0;
    ev.debug_exit      = 1'b0;
    ev.boot_go         = 1'b0;

    case (state_cs)
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) state_ns = BOOT_SET;
      end
      // One cycle boot PC load, keeps fetch_enable_i off the PC path
      BOOT_SET: begin
        pc_set_o   = 1'b1;
        pc_mux_o   = PC_BOOT;
        ev.boot_go = 1'b1;
        state_ns   = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (ev.pending_debug) begin
          if (ev.debug_allowed) begin
            halt_o   = '1;
            state_ns = DEBUG_TAKEN;
          end else begin
            // Hold ID so a bubble reaches WB
            halt_o = STAGE_ID;
          end
        end else if (ev.pending_irq) begin
          if (ev.irq_allowed) begin
            kill_o           = '1;
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_EXCEPTION;
            exc_pc_mux_o     = EXC_PC_IRQ;
            exc_cause        = irq_id_i;
            irq_ack_o        = 1'b1;
            irq_id_o         = irq_id_i;
            csr_save_o       = oldest_stage;
            csr_save_cause_o = 1'b1;
            csr_cause_o      = {1'b1, irq_id_i};
          end else begin
            halt_o = STAGE_ID;
          end
        end else if (ev.exception_wb) begin
          kill_o       = '1;
          pc_set_o     = 1'b1;
          pc_mux_o     = PC_EXCEPTION;
          exc_pc_mux_o = EXC_PC_EXCEPTION;
          csr_save_o   = STAGE_WB;
          // mcause is left alone inside debug mode
          csr_save_cause_o = !ev.debug_mode;
          csr_cause_o      = {1'b0, ev.exc_cause_wb};
        end else if (ev.wfi_wb) begin
          // wfi is a nop in debug mode, EX may still drain into WB
          if (!ev.debug_mode) begin
            halt_o      = STAGE_IF | STAGE_ID;
            instr_req_o = 1'b0;
            state_ns    = SLEEP;
          end
        end else if (ev.dret_wb && ev.debug_mode) begin
          kill_o             = STAGE_IF | STAGE_ID | STAGE_EX;
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_DRET;
          csr_restore_dret_o = 1'b1;
          ev.debug_exit      = 1'b1;
        end else if (ev.branch_taken_ex) begin
          kill_o   = STAGE_IF | STAGE_ID;
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
        end else if (ev.jump_taken_id) begin
          kill_o   = STAGE_IF;
          pc_set_o = 1'b1;
          pc_mux_o = PC_JUMP;
        end
      end
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        // Holding WB stalls everything behind it
        halt_o = STAGE_WB;
        if (irq_wakeup_i || ev.pending_debug) state_ns = FUNCTIONAL;
      end
      DEBUG_TAKEN: begin
        kill_o           = '1;
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_DBD;
        // dpc from the oldest live instruction
        csr_save_o       = oldest_stage;
        debug_csr_save_o = 1'b1;
        ev.debug_enter   = 1'b1;
        state_ns         = FUNCTIONAL;
      end
      default: begin
        instr_req_o = 1'b0;
        state_ns    = RESET;
      end
    endcase
  end

endmodule

// File: hw/ctrl_top.sv
////////////////////
// Pipeline controller top level with plain ports
// Joins the event decoder, debug tracker and main FSM over one event interface
////////////////////
module ctrl_top import ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Core control and interrupt controller
  input  logic        fetch_enable_i,
  input  logic        irq_req_i,
  input  irq_id_t     irq_id_i,
  input  logic        irq_wakeup_i,
  input  logic        mtvec_vectored_i,
  input  logic        debug_req_i,
  input  logic        debug_ebreakm_i,
  input  logic        data_req_i,
  input  logic        ex_done_i,

  // Pipeline stage flags
  input  logic        wb_valid_i,
  input  logic        wb_fetch_err_i,
  input  logic        wb_illegal_i,
  input  logic        wb_ecall_i,
  input  logic        wb_ebreak_i,
  input  logic        wb_wfi_i,
  input  logic        wb_dret_i,
  input  logic        wb_lsu_i,
  input  logic        ex_valid_i,
  input  logic        ex_branch_i,
  input  logic        ex_branch_taken_i,
  input  logic        id_valid_i,
  input  logic        id_jump_i,
  input  logic        jr_stall_i,

  // Controller outputs
  output logic        instr_req_o,
  output logic        ctrl_busy_o,
  output logic        pc_set_o,
  output pc_mux_e     pc_mux_o,
  output exc_pc_mux_e exc_pc_mux_o,
  output irq_id_t     exc_vec_idx_o,
  output stage_mask_t halt_o,
  output stage_mask_t kill_o,
  output stage_mask_t csr_save_o,
  output logic        csr_save_cause_o,
  output csr_cause_t  csr_cause_o,
  output logic        csr_restore_dret_o,
  output logic        irq_ack_o,
  output irq_id_t     irq_id_o,
  output logic        debug_csr_save_o,

  // Debug status
  output logic        debug_mode_o,
  output dbg_cause_e  debug_cause_o,
  output logic        debug_havereset_o,
  output logic        debug_running_o,
  output logic        debug_halted_o
);

  ctrl_event_if u_ev (.clk(clk));

  ctrl_event_decode u_decode (
    .wb_valid_i, .wb_fetch_err_i, .wb_illegal_i, .wb_ecall_i, .wb_ebreak_i,
    .wb_wfi_i, .wb_dret_i, .wb_lsu_i,
    .ex_valid_i, .ex_branch_i, .ex_branch_taken_i,
    .id_valid_i, .id_jump_i, .jr_stall_i,
    .ev (u_ev.decoder)
  );

  ctrl_debug_tracker u_tracker (
    .clk, .rst_n,
    .debug_req_i, .debug_ebreakm_i, .irq_req_i, .data_req_i, .ex_done_i,
    .ev (u_ev.tracker),
    .debug_havereset_o, .debug_running_o, .debug_halted_o
  );

  ctrl_main_fsm u_fsm (
    .clk, .rst_n,
    .fetch_enable_i, .irq_id_i, .irq_wakeup_i, .mtvec_vectored_i,
    .wb_valid_i, .ex_valid_i, .id_valid_i,
    .ev (u_ev.fsm),
    .instr_req_o, .ctrl_busy_o, .pc_set_o, .pc_mux_o, .exc_pc_mux_o, .exc_vec_idx_o,
    .halt_o, .kill_o, .csr_save_o, .csr_save_cause_o, .csr_cause_o,
    .csr_restore_dret_o, .irq_ack_o, .irq_id_o, .debug_csr_save_o
  );

  // Debug mode and cause come straight off the shared events
  assign debug_mode_o  = u_ev.debug_mode;
  assign debug_cause_o = u_ev.debug_cause;

endmodule

// File: test/ctrl_chk.sv
////////////////////
// Concurrent properties on the controller top level
// Bound into ctrl_top, failures are counted for the testbench verdict
////////////////////
module ctrl_chk import ctrl_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        pc_set_o,
  input logic        instr_req_o,
  input logic        irq_ack_o,
  input stage_mask_t csr_save_o,
  input stage_mask_t kill_o
);

  int fail_count = 0;

  // No fetch and no PC load while held in reset or just out of it
  reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
                                (!pc_set_o && !instr_req_o))
    else begin
      $error("pc_set_o or instr_req_o high in RESET");
      fail_count++;
    end

  // At most one save stage
  save_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(csr_save_o))
    else begin
      $error("csr_save_o is multi-hot");
      fail_count++;
    end

  irq_flush: assert property (@(posedge clk) disable iff (!rst_n)
                              irq_ack_o |-> (kill_o == 4'b1111))
    else begin
      $error("irq_ack_o without a full kill");
      fail_count++;
    end

endmodule

bind ctrl_top ctrl_chk u_chk (.*);

// File: test/ctrl_tb.sv
////////////////////
// Table-driven testbench for the pipeline controller
// Builds a row table at time zero, applies one row per clock and checks masked outputs
////////////////////
module ctrl_tb;
  import ctrl_pkg::*;

  typedef struct packed {
    logic       fetch_enable, irq_req;
    logic [4:0] irq_id;
    logic       irq_wakeup, mtvec_vectored, debug_req, debug_ebreakm, data_req, ex_done;
    logic       wb_valid, wb_fetch_err, wb_illegal, wb_ecall, wb_ebreak, wb_wfi, wb_dret;
    logic       wb_lsu, ex_valid, ex_branch, ex_branch_taken, id_valid, id_jump, jr_stall;
  } in_t;

  typedef struct packed {
    logic       instr_req, busy, pc_set;
    logic [2:0] pc_mux;
    logic [1:0] exc_pc_mux;
    logic [4:0] vec_idx;
    logic [3:0] halt, kill, csr_save;
    logic       save_cause;
    logic [5:0] cause;
    logic       dret, irq_ack;
    logic [4:0] irq_id;
    logic       dcsr_save, dbg_mode;
    logic [2:0] dbg_cause;
    logic       havereset, running, halted;
  } out_t;

  logic clk = 1'b0;
  logic rst_n;
  in_t  din;
  out_t dout;
  logic [2:0] pc_mux, dbg_cause;
  logic [1:0] exc_pc_mux;
  logic [4:0] vec_idx, irq_id;
  logic [3:0] halt, kill, csr_save;
  logic [5:0] cause;
  logic instr_req, busy, pc_set, save_cause, dret, irq_ack, dcsr_save;
  logic dbg_mode, havereset, running, halted;

  // Row table and the row under construction
  in_t  in_q[$];
  out_t exp_q[$];
  out_t care_q[$];
  int   test_q[$];
  in_t  cur_in;
  out_t cur_exp;
  out_t cur_care;

  string names[6] = '{"boot", "exceptions", "interrupts", "debug", "sleep", "branch_jump"};
  int    test_err[6];
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  int    limit = 1000;
  logic [15:0] lfsr = 16'd6211;

  always #20 clk = ~clk;

  ctrl_top u_ctrl_top (
    .clk, .rst_n,
    .fetch_enable_i(din.fetch_enable), .irq_req_i(din.irq_req), .irq_id_i(din.irq_id),
    .irq_wakeup_i(din.irq_wakeup), .mtvec_vectored_i(din.mtvec_vectored),
    .debug_req_i(din.debug_req), .debug_ebreakm_i(din.debug_ebreakm),
    .data_req_i(din.data_req), .ex_done_i(din.ex_done),
    .wb_valid_i(din.wb_valid), .wb_fetch_err_i(din.wb_fetch_err),
    .wb_illegal_i(din.wb_illegal), .wb_ecall_i(din.wb_ecall), .wb_ebreak_i(din.wb_ebreak),
    .wb_wfi_i(din.wb_wfi), .wb_dret_i(din.wb_dret), .wb_lsu_i(din.wb_lsu),
    .ex_valid_i(din.ex_valid), .ex_branch_i(din.ex_branch),
    .ex_branch_taken_i(din.ex_branch_taken), .id_valid_i(din.id_valid),
    .id_jump_i(din.id_jump), .jr_stall_i(din.jr_stall),
    .instr_req_o(instr_req), .ctrl_busy_o(busy), .pc_set_o(pc_set), .pc_mux_o(pc_mux),
    .exc_pc_mux_o(exc_pc_mux), .exc_vec_idx_o(vec_idx), .halt_o(halt), .kill_o(kill),
    .csr_save_o(csr_save), .csr_save_cause_o(save_cause), .csr_cause_o(cause),
    .csr_restore_dret_o(dret), .irq_ack_o(irq_ack), .irq_id_o(irq_id),
    .debug_csr_save_o(dcsr_save), .debug_mode_o(dbg_mode), .debug_cause_o(dbg_cause),
    .debug_havereset_o(havereset), .debug_running_o(running), .debug_halted_o(halted)
  );

  assign dout = {instr_req, busy, pc_set, pc_mux, exc_pc_mux, vec_idx, halt, kill, csr_save,
                 save_cause, cause, dret, irq_ack, irq_id, dcsr_save, dbg_mode, dbg_cause,
                 havereset, running, halted};

  // Galois LFSR stepped once per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Quiet pipeline is the baseline for every row
  task automatic new_row();
    cur_in   = '0;
    cur_exp  = '0;
    cur_care = '0;
    cur_care.pc_set     = 1'b1;
    cur_care.halt       = '1;
    cur_care.kill       = '1;
    cur_care.irq_ack    = 1'b1;
    cur_care.irq_id     = '1;
    cur_care.save_cause = 1'b1;
    cur_care.dcsr_save  = 1'b1;
    cur_care.dret       = 1'b1;
  endtask

  task automatic ctrl_exp(input logic req, input logic bsy, input logic set,
                          input logic [3:0] h, input logic [3:0] k);
    cur_exp.instr_req = req;
    cur_exp.busy      = bsy;
    cur_exp.pc_set    = set;
    cur_exp.halt      = h;
    cur_exp.kill      = k;
    cur_care.instr_req = 1'b1;
    cur_care.busy      = 1'b1;
  endtask

  task automatic pc_exp(input logic [2:0] mux, input logic [1:0] emux);
    cur_exp.pc_mux      = mux;
    cur_exp.exc_pc_mux  = emux;
    cur_care.pc_mux     = '1;
    cur_care.exc_pc_mux = '1;
  endtask

  task automatic csr_exp(input logic [3:0] save, input logic sc, input logic [5:0] c,
                         input logic ack, input logic [4:0] vidx);
    cur_exp.csr_save   = save;
    cur_exp.save_cause = sc;
    cur_exp.cause      = c;
    cur_exp.irq_ack    = ack;
    cur_exp.vec_idx    = vidx;
    cur_care.csr_save = '1;
    cur_care.cause    = '1;
    cur_care.vec_idx  = '1;
  endtask

  task automatic dbg_exp(input logic m, input logic hr, input logic run, input logic hlt);
    cur_exp.dbg_mode  = m;
    cur_exp.havereset = hr;
    cur_exp.running   = run;
    cur_exp.halted    = hlt;
    cur_care.dbg_mode  = 1'b1;
    cur_care.havereset = 1'b1;
    cur_care.running   = 1'b1;
    cur_care.halted    = 1'b1;
  endtask

  task automatic push_row(input int t);
    in_q.push_back(cur_in);
    exp_q.push_back(cur_exp);
    care_q.push_back(cur_care);
    test_q.push_back(t);
  endtask

  task automatic add_idle(input int t);
    new_row();
    ctrl_exp(1, 1, 0, 4'b0000, 4'b0000);
    push_row(t);
  endtask

  task automatic pad(input int t);
    int n;
    n = rand_bits(2);
    repeat (n) add_idle(t);
  endtask

  task automatic fill_table();
    int id_a;
    int id_b;
    id_a = rand_bits(5);
    id_b = rand_bits(5);
    // Fetch enable seen in RESET gives one BOOT_SET cycle
    new_row();
    ctrl_exp(0, 1, 0, 0, 0);
    dbg_exp(0, 1, 0, 0);
    push_row(0);
    new_row();
    cur_in.fetch_enable = 1;
    ctrl_exp(0, 1, 0, 0, 0);
    push_row(0);
    new_row();
    cur_in.fetch_enable = 1;
    ctrl_exp(1, 1, 1, 0, 0);
    pc_exp(PC_BOOT, EXC_PC_EXCEPTION);
    dbg_exp(0, 1, 0, 0);
    push_row(0);
    new_row();
    ctrl_exp(1, 1, 0, 0, 0);
    dbg_exp(0, 0, 1, 0);
    push_row(0);
    pad(1);
    // Exception cause picked by priority
    new_row();
    cur_in.wb_valid = 1;
    cur_in.wb_fetch_err = 1;
    cur_in.wb_illegal = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    pc_exp(PC_EXCEPTION, EXC_PC_EXCEPTION);
    csr_exp(4'b1000, 1, 6'd1, 0, 0);
    push_row(1);
    new_row();
    cur_in.wb_valid = 1;
    cur_in.wb_illegal = 1;
    cur_in.wb_ecall = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    csr_exp(4'b1000, 1, 6'd2, 0, 0);
    push_row(1);
    new_row();
    cur_in.wb_valid = 1;
    cur_in.wb_ecall = 1;
    cur_in.wb_ebreak = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    csr_exp(4'b1000, 1, 6'd11, 0, 0);
    push_row(1);
    new_row();
    cur_in.wb_valid = 1;
    cur_in.wb_ebreak = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    csr_exp(4'b1000, 1, 6'd3, 0, 0);
    push_row(1);
    // Flag on an empty WB slot is ignored
    new_row();
    cur_in.wb_fetch_err = 1;
    ctrl_exp(1, 1, 0, 0, 0);
    push_row(1);
    pad(2);
    // Interrupts held off by LSU in WB and then by an open data request
    new_row();
    cur_in.irq_req = 1;
    cur_in.irq_id = id_a[4:0];
    cur_in.mtvec_vectored = 1;
    cur_in.wb_valid = 1;
    cur_in.wb_lsu = 1;
    cur_in.ex_valid = 1;
    ctrl_exp(1, 1, 0, 4'b0010, 0);
    push_row(2);
    new_row();
    cur_in.irq_req = 1;
    cur_in.irq_id = id_a[4:0];
    cur_in.mtvec_vectored = 1;
    cur_in.ex_valid = 1;
    cur_in.id_valid = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    pc_exp(PC_EXCEPTION, EXC_PC_IRQ);
    csr_exp(4'b0100, 1, {1'b1, id_a[4:0]}, 1, id_a[4:0]);
    cur_exp.irq_id = id_a[4:0];
    push_row(2);
    new_row();
    cur_in.data_req = 1;
    ctrl_exp(1, 1, 0, 0, 0);
    push_row(2);
    new_row();
    cur_in.irq_req = 1;
    cur_in.irq_id = id_b[4:0];
    cur_in.ex_done = 1;
    ctrl_exp(1, 1, 0, 4'b0010, 0);
    push_row(2);
    new_row();
    cur_in.irq_req = 1;
    cur_in.irq_id = id_b[4:0];
    cur_in.id_valid = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    csr_exp(4'b0010, 1, {1'b1, id_b[4:0]}, 1, 5'd0);
    cur_exp.irq_id = id_b[4:0];
    push_row(2);
    pad(3);
    // Debug entry by request and exit by dret
    new_row();
    cur_in.debug_req = 1;
    cur_in.id_valid = 1;
    ctrl_exp(1, 1, 0, 4'hF, 0);
    cur_exp.dbg_cause = HALTREQ;
    cur_care.dbg_cause = '1;
    push_row(3);
    new_row();
    cur_in.id_valid = 1;
    ctrl_exp(1, 1, 1, 0, 4'hF);
    pc_exp(PC_EXCEPTION, EXC_PC_DBD);
    dbg_exp(0, 0, 1, 0);
    cur_exp.dbg_cause = HALTREQ;
    cur_care.dbg_cause = '1;
    cur_exp.csr_save = 4'b0010;
    cur_care.csr_save = '1;
    cur_exp.dcsr_save = 1;
    push_row(3);
    new_row();
    ctrl_exp(1, 1, 0, 0, 0);
    dbg_exp(1, 0, 0, 1);
    push_row(3);
    new_row();
    cur_in.wb_valid = 1;
    cur_in.wb_dret = 1;
    ctrl_exp(1, 1, 1, 0, 4'b0111);
    pc_exp(PC_DRET, EXC_PC_EXCEPTION);
    dbg_exp(1, 0, 0, 1);
    cur_exp.dret = 1;
    push_row(3);
    new_row();
    ctrl_exp(1, 1, 0, 0, 0);
    dbg_exp(0, 0, 1, 0);
    push_row(3);
    pad(4);
    // Sleep on wfi and wake one cycle after irq_wakeup_i
    new_row();
    cur_in.wb_valid = 1;
    cur_in.wb_wfi = 1;
    ctrl_exp(0, 1, 0, 4'b0011, 0);
    push_row(4);
    new_row();
    ctrl_exp(0, 0, 0, 4'b1000, 0);
    push_row(4);
    new_row();
    cur_in.irq_wakeup = 1;
    ctrl_exp(0, 0, 0, 4'b1000, 0);
    push_row(4);
    new_row();
    ctrl_exp(1, 1, 0, 0, 0);
    push_row(4);
    pad(5);
    // Branch and jump kills
    new_row();
    cur_in.ex_valid = 1;
    cur_in.ex_branch = 1;
    cur_in.ex_branch_taken = 1;
    cur_in.id_valid = 1;
    cur_in.id_jump = 1;
    ctrl_exp(1, 1, 1, 0, 4'b0011);
    pc_exp(PC_BRANCH, EXC_PC_EXCEPTION);
    push_row(5);
    new_row();
    cur_in.ex_valid = 1;
    cur_in.ex_branch = 1;
    ctrl_exp(1, 1, 0, 0, 0);
    push_row(5);
    new_row();
    cur_in.id_valid = 1;
    cur_in.id_jump = 1;
    ctrl_exp(1, 1, 1, 0, 4'b0001);
    pc_exp(PC_JUMP, EXC_PC_EXCEPTION);
    push_row(5);
    new_row();
    cur_in.id_valid = 1;
    cur_in.id_jump = 1;
    cur_in.jr_stall = 1;
    ctrl_exp(1, 1, 0, 0, 0);
    push_row(5);
  endtask

  // Run limit guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    din   = '0;
    rst_n = 1'b0;
    fill_table();
    limit = in_q.size() + 20;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < in_q.size(); i++) begin
      @(posedge clk);
      din <= in_q[i];
      @(negedge clk);
      checks++;
      if (((dout ^ exp_q[i]) & care_q[i]) != '0) begin
        errors++;
        test_err[test_q[i]]++;
        $display("ERROR t=%0t row %0d: outputs %h expected %h care %h",
                 $time, i, dout, exp_q[i], care_q[i]);
      end
      if (i == in_q.size() - 1 || test_q[i + 1] != test_q[i]) begin
        $display("test %0d %s: %0d errors", test_q[i], names[test_q[i]], test_err[test_q[i]]);
      end
    end
    // Last row is sampled by the properties on the next rising edge
    @(posedge clk);
    @(negedge clk);
    errors = errors + u_ctrl_top.u_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, u_ctrl_top.u_chk.fail_count);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/ctrl_pkg.sv
common/ctrl_event_if.sv
hw/ctrl_event_decode.sv
hw/ctrl_debug_tracker.sv
ctrl_fsm/ctrl_main_fsm.sv
hw/ctrl_top.sv
test/ctrl_chk.sv
test/ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f filelist.f --top-module ctrl_tb \
  --Mdir obj_dir -o ctrl_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/ctrl_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "no verdict found in sim.log"
  exit 1
fi
exit 0
